// File: Bender.yml
package:
  name: memory_system

sources:
  - include_dirs:
      - .
    files:
      - memPkg.sv
      - wbPkg.sv
      - memoryController.sv
      - localMemory.sv
      - wbBridge.sv
      - wbRam.sv
      - memorySystem.sv
      - tbClock.sv
      - memorySystemTb.sv

// File: localMemory.sv
`timescale 1ns/10ps
`default_nettype none

`include "memorySystem_config.svh"

module localMemory (
	input wire logic clk,
	input wire logic rst,
	input wire memPkg::targetRequest_t request,
	output memPkg::coreResponse_t response
);

	localparam int IndexBits = $clog2(`MEM_LOCAL_WORDS);

	memPkg::data_t memory [`MEM_LOCAL_WORDS];
	memPkg::data_t readWord;
	memPkg::localAddress_t localOffset;
	logic [IndexBits-1:0] wordIndex;
	logic phase; // set during the second cycle of an access.
	logic access;

	assign localOffset = request.offset[23:0];
	assign wordIndex = localOffset[IndexBits+1:2]; // byte offset to word index.
	assign access = request.enable && !phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= 1'b0;
		end else begin
			phase <= access;
		end
	end

	// --------------------------------------------------
	// word array with byte lanes
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (access) begin
			readWord <= memory[wordIndex];
			if (request.writeEnable) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (request.byteSelect[lane]) begin
						memory[wordIndex][lane*8 +: 8] <= request.writeData[lane*8 +: 8];
					end
				end
			end
		end
	end

	// busy only in the first cycle, the registered word is ready in the second.
	assign response = '{readData: readWord, busy: access};

	writeHasLanes: assert property (@(posedge clk) disable iff (rst)
		(request.enable && request.writeEnable) |-> (request.byteSelect != '0));

endmodule

`default_nettype wire

// File: memPkg.sv
`default_nettype none

package memPkg;

	typedef logic [31:0] address_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] byteSelect_t;
	typedef logic [23:0] localAddress_t;

	// fetches are always full-word reads, so no byte select or write data.
	typedef struct packed {
		address_t address;
		logic enable;
	} instrRequest_t;

	typedef struct packed {
		address_t address;
		byteSelect_t byteSelect;
		logic enable;
		logic writeEnable;
		data_t writeData;
	} dataRequest_t;

	typedef struct packed {
		data_t readData;
		logic busy;
	} coreResponse_t;

	typedef struct packed {
		logic [27:0] offset; // local memory only looks at the low 24 bits.
		byteSelect_t byteSelect;
		logic enable;
		logic writeEnable;
		data_t writeData;
	} targetRequest_t;

	typedef enum logic [1:0] {sourceNone, sourceInstruction, sourceData} source_t;

endpackage

`default_nettype wire

// File: memoryController.sv
`timescale 1ns/10ps
`default_nettype none

module memoryController (
	input wire logic clk,
	input wire logic rst,
	input wire memPkg::instrRequest_t instrRequest,
	input wire memPkg::dataRequest_t dataRequest,
	input wire memPkg::coreResponse_t localResponse,
	input wire memPkg::coreResponse_t wbResponse,
	output memPkg::coreResponse_t instrResponse,
	output memPkg::coreResponse_t dataResponse,
	output memPkg::targetRequest_t localRequest,
	output memPkg::targetRequest_t wbRequest
);

	logic instrLocalHit;
	logic instrWbHit;
	logic dataLocalHit;
	logic dataWbHit;
	memPkg::source_t localOwner;
	memPkg::source_t wbOwner;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------

	assign instrLocalHit = instrRequest.enable && (instrRequest.address[31:24] == 8'h00);
	assign instrWbHit = instrRequest.enable && (instrRequest.address[31:28] == 4'h1);
	assign dataLocalHit = dataRequest.enable && (dataRequest.address[31:24] == 8'h00);
	assign dataWbHit = dataRequest.enable && (dataRequest.address[31:28] == 4'h1);

	// an owner keeps the target until it stops hitting it, then the other port may take over.
	function automatic memPkg::source_t nextOwner(
		input memPkg::source_t owner,
		input logic instrHit,
		input logic dataHit
	);
		memPkg::source_t owned;
		owned = owner;
		case (owner)
			memPkg::sourceInstruction: begin
				if (!instrHit) owned = dataHit ? memPkg::sourceData : memPkg::sourceNone;
			end
			memPkg::sourceData: begin
				if (!dataHit) owned = instrHit ? memPkg::sourceInstruction : memPkg::sourceNone;
			end
			default: begin
				if (instrHit) owned = memPkg::sourceInstruction;
				else if (dataHit) owned = memPkg::sourceData;
				else owned = memPkg::sourceNone;
			end
		endcase
		return owned;
	endfunction

	// an idle target is routed the same cycle, with the same priority the register will take.
	function automatic memPkg::targetRequest_t route(
		input memPkg::source_t owner,
		input logic instrHit,
		input logic dataHit
	);
		memPkg::targetRequest_t req;
		memPkg::source_t pick;
		pick = (owner == memPkg::sourceNone) ? nextOwner(owner, instrHit, dataHit) : owner;
		req = '0;
		case (pick)
			memPkg::sourceInstruction: begin
				req.offset = instrRequest.address[27:0];
				req.byteSelect = 4'b1111;
				req.enable = instrHit;
			end
			memPkg::sourceData: begin
				req.offset = dataRequest.address[27:0];
				req.byteSelect = dataRequest.byteSelect;
				req.enable = dataHit;
				req.writeEnable = dataRequest.writeEnable;
				req.writeData = dataRequest.writeData;
			end
			default: ;
		endcase
		return req;
	endfunction

	// a port only sees a target's response while it owns it and still addresses it.
	function automatic memPkg::coreResponse_t respond(
		input memPkg::source_t port,
		input logic localHit,
		input logic wbHit
	);
		memPkg::coreResponse_t rsp;
		rsp.readData = '1;
		rsp.busy = 1'b1;
		if (localOwner == port && localHit) rsp = localResponse;
		else if (wbOwner == port && wbHit) rsp = wbResponse;
		return rsp;
	endfunction

	// --------------------------------------------------
	// ownership per target
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			localOwner <= memPkg::sourceNone;
			wbOwner <= memPkg::sourceNone;
		end else begin
			localOwner <= nextOwner(localOwner, instrLocalHit, dataLocalHit);
			wbOwner <= nextOwner(wbOwner, instrWbHit, dataWbHit);
		end
	end

	always_comb begin
		localRequest = route(localOwner, instrLocalHit, dataLocalHit);
		wbRequest = route(wbOwner, instrWbHit, dataWbHit);
		instrResponse = respond(memPkg::sourceInstruction, instrLocalHit, instrWbHit);
		dataResponse = respond(memPkg::sourceData, dataLocalHit, dataWbHit);
	end

	// a request issued to an idle target turns into ownership on the next cycle.
	localTakeover: assert property (@(posedge clk) disable iff (rst)
		(localOwner == memPkg::sourceNone && localRequest.enable)
		|=> (localOwner != memPkg::sourceNone));

	wbTakeover: assert property (@(posedge clk) disable iff (rst)
		(wbOwner == memPkg::sourceNone && wbRequest.enable)
		|=> (wbOwner != memPkg::sourceNone));

	singleTarget: assert property (@(posedge clk) disable iff (rst)
		!(localOwner != memPkg::sourceNone && localOwner == wbOwner));

endmodule

`default_nettype wire

// File: memorySystem.sv
`timescale 1ns/10ps
`default_nettype none

module memorySystem (
	input wire logic clk,
	input wire logic rst,
	input wire memPkg::instrRequest_t instrRequest,
	input wire memPkg::dataRequest_t dataRequest,
	output memPkg::coreResponse_t instrResponse,
	output memPkg::coreResponse_t dataResponse
);

	memPkg::targetRequest_t localRequest;
	memPkg::targetRequest_t wbRequest;
	memPkg::coreResponse_t localResponse;
	memPkg::coreResponse_t wbResponse;
	wbPkg::wbMaster_t busMaster;
	wbPkg::wbSlave_t busSlave;

	memoryController controller0 (
		.clk(clk),
		.rst(rst),
		.instrRequest(instrRequest),
		.dataRequest(dataRequest),
		.localResponse(localResponse),
		.wbResponse(wbResponse),
		.instrResponse(instrResponse),
		.dataResponse(dataResponse),
		.localRequest(localRequest),
		.wbRequest(wbRequest)
	);

	localMemory localMemory0 (.clk(clk), .rst(rst), .request(localRequest), .response(localResponse));

	// the bus RAM stands in for the Wishbone interconnect.
	wbBridge wbBridge0 (
		.clk(clk),
		.rst(rst),
		.request(wbRequest),
		.slave(busSlave),
		.response(wbResponse),
		.master(busMaster)
	);

	wbRam wbRam0 (.clk(clk), .rst(rst), .master(busMaster), .slave(busSlave));

endmodule

`default_nettype wire

// File: memorySystemTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "memorySystem_config.svh"

module memorySystemTb;

	localparam int TestWords = 16;
	localparam int WaitLimit = 200;

	logic clk;
	logic rst;
	memPkg::instrRequest_t instrRequest;
	memPkg::dataRequest_t dataRequest;
	memPkg::coreResponse_t instrResponse;
	memPkg::coreResponse_t dataResponse;

	memPkg::data_t localShadow [`MEM_LOCAL_WORDS];
	memPkg::data_t wbShadow [`WB_RAM_WORDS];
	memPkg::address_t localAddresses [TestWords];
	memPkg::address_t wbAddresses [TestWords];
	memPkg::data_t expectedQueue [$];
	memPkg::data_t actualQueue [$];
	string nameQueue [$];
	int readsQueued;
	int readsChecked;
	int cycleCount;
	int instrDoneCycle;
	int dataDoneCycle;

	tbClock clock0 (.clk(clk), .rst(rst));

	memorySystem dut0 (
		.clk(clk),
		.rst(rst),
		.instrRequest(instrRequest),
		.dataRequest(dataRequest),
		.instrResponse(instrResponse),
		.dataResponse(dataResponse)
	);

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkData(input string testName, input memPkg::data_t expected,
		input memPkg::data_t actual);
		if (actual !== expected) failRun($sformatf("ERR %s expected %h actual %h", testName,
			expected, actual));
	endtask

	task automatic checkBusy(input string testName, input bit expected, input bit actual);
		if (actual !== expected) failRun($sformatf("ERR %s expected %b actual %b", testName,
			expected, actual));
	endtask

	// --------------------------------------------------
	// reference model of both memories
	// --------------------------------------------------

	function automatic memPkg::data_t mergeLanes(input memPkg::data_t oldWord,
		input memPkg::data_t newWord, input memPkg::byteSelect_t byteSelect);
		memPkg::data_t merged;
		merged = oldWord;
		for (int lane = 0; lane < 4; lane++) begin
			if (byteSelect[lane]) merged[lane*8 +: 8] = newWord[lane*8 +: 8];
		end
		return merged;
	endfunction

	// applies a write to the shadow and returns the word a read would see.
	function automatic memPkg::data_t refAccess(input memPkg::address_t address,
		input memPkg::byteSelect_t byteSelect, input logic write, input memPkg::data_t writeData);
		int index;
		memPkg::data_t word;
		word = '1; // unmapped space reads as all ones.
		if (address[31:24] == 8'h00) begin
			index = int'(address[23:2]) % `MEM_LOCAL_WORDS;
			if (write) localShadow[index] = mergeLanes(localShadow[index], writeData, byteSelect);
			word = localShadow[index];
		end else if (address[31:28] == 4'h1) begin
			index = int'(address[27:2]) % `WB_RAM_WORDS;
			if (write) wbShadow[index] = mergeLanes(wbShadow[index], writeData, byteSelect);
			word = wbShadow[index];
		end
		return word;
	endfunction

	task automatic queueRead(input string testName, input memPkg::data_t expected,
		input memPkg::data_t actual);
		nameQueue.push_back(testName);
		expectedQueue.push_back(expected);
		actualQueue.push_back(actual);
		readsQueued++;
	endtask

	// every completed read is compared on the following rising edge.
	always @(posedge clk) begin
		while (expectedQueue.size() > 0) begin
			checkData(nameQueue.pop_front(), expectedQueue.pop_front(), actualQueue.pop_front());
			readsChecked++;
		end
	end

	// --------------------------------------------------
	// port drivers
	// --------------------------------------------------

	task automatic dataAccess(input string testName, input memPkg::address_t address,
		input memPkg::byteSelect_t byteSelect, input logic write, input memPkg::data_t writeData);
		int waited;
		@(posedge clk);
		dataRequest <= '{address: address, byteSelect: byteSelect, enable: 1'b1,
			writeEnable: write, writeData: writeData};
		waited = 0;
		@(negedge clk);
		while (dataResponse.busy) begin
			waited++;
			if (waited >= WaitLimit) failRun($sformatf("data port hung during %s", testName));
			@(negedge clk);
		end
		dataDoneCycle = cycleCount;
		if (write) void'(refAccess(address, byteSelect, write, writeData));
		else queueRead(testName, refAccess(address, byteSelect, 1'b0, '0), dataResponse.readData);
		@(posedge clk);
		dataRequest <= '0;
	endtask

	task automatic fetch(input string testName, input memPkg::address_t address);
		int waited;
		@(posedge clk);
		instrRequest <= '{address: address, enable: 1'b1};
		waited = 0;
		@(negedge clk);
		while (instrResponse.busy) begin
			waited++;
			if (waited >= WaitLimit) failRun($sformatf("instruction port hung during %s", testName));
			@(negedge clk);
		end
		instrDoneCycle = cycleCount;
		queueRead(testName, refAccess(address, 4'b1111, 1'b0, '0), instrResponse.readData);
		@(posedge clk);
		instrRequest <= '0;
	endtask

	initial begin
		int waited;
		int index;
		instrRequest = '0;
		dataRequest = '0;
		void'($urandom(99234));
		@(negedge clk);
		checkBusy("reset instruction busy", 1'b1, instrResponse.busy);
		checkData("reset instruction readData", '1, instrResponse.readData);
		checkBusy("reset data busy", 1'b1, dataResponse.busy);
		checkData("reset data readData", '1, dataResponse.readData);
		waited = 0;
		while (rst) begin
			waited++;
			if (waited >= WaitLimit) failRun("reset was never released");
			@(posedge clk);
		end
		// full write first so that every byte of the word is known.
		for (int i = 0; i < TestWords; i++) begin
			index = $urandom_range(`MEM_LOCAL_WORDS - 1, 0);
			localAddresses[i] = memPkg::address_t'(index * 4);
			dataAccess("local full write", localAddresses[i], 4'b1111, 1'b1, $urandom);
			dataAccess("local byte write", localAddresses[i], 4'($urandom_range(15, 1)), 1'b1,
				$urandom);
			dataAccess("local read", localAddresses[i], 4'b1111, 1'b0, '0);
		end
		for (int i = 0; i < TestWords; i++) begin
			index = $urandom_range(`WB_RAM_WORDS - 1, 0);
			wbAddresses[i] = 32'h1000_0000 | memPkg::address_t'(index * 4);
			dataAccess("bus full write", wbAddresses[i], 4'b1111, 1'b1, $urandom);
			dataAccess("bus byte write", wbAddresses[i], 4'($urandom_range(15, 1)), 1'b1, $urandom);
			dataAccess("bus read", wbAddresses[i], 4'b1111, 1'b0, '0);
		end
		for (int i = 0; i < TestWords; i++) begin
			fetch("local fetch", localAddresses[i]);
			fetch("bus fetch", wbAddresses[i]);
		end
		fork
			fetch("shared local fetch", localAddresses[0]);
			dataAccess("shared local read", localAddresses[1], 4'b1111, 1'b0, '0);
		join
		if (instrDoneCycle >= dataDoneCycle) failRun("instruction port lost local memory to data");
		fork
			fetch("shared bus fetch", wbAddresses[0]);
			dataAccess("shared bus read", wbAddresses[1], 4'b1111, 1'b0, '0);
		join
		if (instrDoneCycle >= dataDoneCycle) failRun("instruction port lost the bus to data");
		fork
			begin
				@(posedge clk); // the fetch starts while the bus write is already in flight.
				fetch("parallel local fetch", localAddresses[2]);
			end
			dataAccess("parallel bus write", wbAddresses[2], 4'b1111, 1'b1, $urandom);
		join
		if (instrDoneCycle >= dataDoneCycle) failRun("local fetch waited for the bus access");
		dataAccess("parallel bus read", wbAddresses[2], 4'b1111, 1'b0, '0);
		@(posedge clk);
		instrRequest <= '{address: 32'h0100_0000, enable: 1'b1};
		dataRequest <= '{address: 32'h2000_0040, byteSelect: 4'b1111, enable: 1'b1,
			writeEnable: 1'b0, writeData: '0};
		repeat (20) begin
			@(negedge clk);
			checkBusy("unmapped instruction busy", 1'b1, instrResponse.busy);
			checkData("unmapped instruction readData", '1, instrResponse.readData);
			checkBusy("unmapped data busy", 1'b1, dataResponse.busy);
			checkData("unmapped data readData", '1, dataResponse.readData);
		end
		@(posedge clk);
		instrRequest <= '0;
		dataRequest <= '0;
		fetch("fetch after unmapped", wbAddresses[3]);
		dataAccess("read after unmapped", localAddresses[3], 4'b1111, 1'b0, '0);
		waited = 0;
		@(negedge clk);
		while (expectedQueue.size() > 0) begin
			waited++;
			if (waited >= WaitLimit) failRun("compare process never drained its queue");
			@(negedge clk);
		end
		if (readsChecked == readsQueued && readsQueued > 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			failRun($sformatf("only %0d of %0d reads were compared", readsChecked, readsQueued));
		end
	end

endmodule

`default_nettype wire

// File: memorySystem_config.svh
`ifndef MEMORY_SYSTEM_CONFIG_SVH
`define MEMORY_SYSTEM_CONFIG_SVH

// --------------------------------------------------
// memory depths
// --------------------------------------------------

// depth of the tightly-coupled local memory in 32-bit words.
`define MEM_LOCAL_WORDS 1024

// depth of the RAM behind the Wishbone bus in 32-bit words.
`define WB_RAM_WORDS 256

// cycles with stb high before the bus RAM raises ack.
`define WB_WAIT_STATES 2

`endif

// File: tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

	// reset covers the first five rising edges.
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
memPkg.sv
wbPkg.sv
memoryController.sv
localMemory.sv
wbBridge.sv
wbRam.sv
memorySystem.sv
tbClock.sv
memorySystemTb.sv

// File: wbBridge.sv
`timescale 1ns/10ps
`default_nettype none

module wbBridge (
	input wire logic clk,
	input wire logic rst,
	input wire memPkg::targetRequest_t request,
	input wire wbPkg::wbSlave_t slave,
	output memPkg::coreResponse_t response,
	output wbPkg::wbMaster_t master
);

	wbPkg::bridgeState_t state;
	logic cycle; // classic single cycles raise and drop cyc and stb together.
	wbPkg::wbAddress_t adr;
	memPkg::data_t datW;
	memPkg::byteSelect_t sel;
	logic we;
	memPkg::data_t readData;

	// --------------------------------------------------
	// cycle control
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wbPkg::bridgeIdle;
			cycle <= 1'b0;
		end else begin
			case (state)
				wbPkg::bridgeIdle: begin
					if (request.enable) begin
						state <= wbPkg::bridgeWait;
						cycle <= 1'b1;
					end
				end
				wbPkg::bridgeWait: begin
					if (slave.ack) begin
						state <= wbPkg::bridgeDone;
						cycle <= 1'b0;
					end
				end
				default: state <= wbPkg::bridgeIdle; // done lasts a single cycle.
			endcase
		end
	end

	// request fields are frozen for the whole bus cycle.
	always_ff @(posedge clk) begin
		if (state == wbPkg::bridgeIdle && request.enable) begin
			adr <= request.offset;
			datW <= request.writeData;
			sel <= request.byteSelect;
			we <= request.writeEnable;
		end
		if (state == wbPkg::bridgeWait && slave.ack) begin
			readData <= slave.datR;
		end
	end

	assign master = '{adr: adr, datW: datW, sel: sel, we: we, cyc: cycle, stb: cycle};
	assign response = '{readData: readData, busy: (state != wbPkg::bridgeDone)};

	// a strobe stays up inside its cycle with the same address until the slave acknowledges.
	stbHeldToAck: assert property (@(posedge clk) disable iff (rst)
		(master.stb && !slave.ack) |=> (master.cyc && master.stb && $stable(master.adr)));

endmodule

`default_nettype wire

// File: wbPkg.sv
`default_nettype none

package wbPkg;

	typedef logic [27:0] wbAddress_t;

	// signals driven by the bus master.
	typedef struct packed {
		wbAddress_t adr;
		memPkg::data_t datW;
		memPkg::byteSelect_t sel;
		logic we;
		logic cyc;
		logic stb;
	} wbMaster_t;

	// signals driven by the bus slave.
	typedef struct packed {
		memPkg::data_t datR;
		logic ack;
	} wbSlave_t;

	typedef enum logic [1:0] {bridgeIdle, bridgeWait, bridgeDone} bridgeState_t;

endpackage

`default_nettype wire

// File: wbRam.sv
`timescale 1ns/10ps
`default_nettype none

`include "memorySystem_config.svh"

module wbRam (
	input wire logic clk,
	input wire logic rst,
	input wire wbPkg::wbMaster_t master,
	output wbPkg::wbSlave_t slave
);

	localparam int IndexBits = $clog2(`WB_RAM_WORDS);
	localparam int CountBits = $clog2(`WB_WAIT_STATES + 1);
	localparam logic [CountBits-1:0] LastWait = CountBits'(`WB_WAIT_STATES - 1);

	memPkg::data_t memory [`WB_RAM_WORDS];
	memPkg::data_t readWord;
	logic [IndexBits-1:0] wordIndex;
	logic [CountBits-1:0] waitCount;
	logic ack;
	logic pending; // strobe that has not been acknowledged yet.

	assign wordIndex = master.adr[IndexBits+1:2];
	assign pending = master.cyc && master.stb && !ack;

	// --------------------------------------------------
	// wait states and ack
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			waitCount <= '0;
		end else if (pending) begin
			if (waitCount == LastWait) begin
				ack <= 1'b1;
				waitCount <= '0;
			end else begin
				waitCount <= waitCount + 1'b1;
			end
		end else begin
			ack <= 1'b0; // ack is high for exactly one cycle.
			waitCount <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (pending && waitCount == LastWait) begin
			readWord <= memory[wordIndex];
		end
		if (ack && master.we) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (master.sel[lane]) memory[wordIndex][lane*8 +: 8] <= master.datW[lane*8 +: 8];
			end
		end
	end

	assign slave = '{datR: readWord, ack: ack};

endmodule

`default_nettype wire
